//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - src/rv_core_pkg.sv
      - src/rv_decoder.sv
      - src/rv_regfile.sv
      - src/rv_execute.sv
      - src/rv_pc_unit.sv
      - src/rv_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/tb_rv_core.sv

//--- flist.f
+incdir+include
src/rv_core_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_pc_unit.sv
src/rv_core.sv
verification/tb_rv_core.sv

//--- src/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    output logic [rv_core_pkg::XLEN-1:0]    imem_addr_o,
    input  logic [rv_core_pkg::XLEN-1:0]    imem_inst_i,
    output rv_core_pkg::dbus_t              dbus_o,
    input  logic [rv_core_pkg::XLEN-1:0]    dmem_rdata_i,
    output logic                            halt_o
);
    import rv_core_pkg::*;

    ctrl_t                 ctrl;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       alu_res;
    logic [XLEN-1:0]       wb_data;
    logic [XLEN-1:0]       target;
    logic [XLEN-1:0]       pc;
    logic                  redirect;
    logic                  commit;

    rv_decoder u_decoder (
        .inst_i     (imem_inst_i),
        .ctrl_o     (ctrl),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr),
        .imm_o      (imm)
    );

    rv_regfile u_regfile (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .we_i     (ctrl.rf_wen & commit),
        .waddr_i  (rd_addr),
        .wdata_i  (wb_data),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    rv_execute u_execute (
        .ctrl_i      (ctrl),
        .pc_i        (pc),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .imm_i       (imm),
        .mem_rdata_i (dmem_rdata_i),
        .alu_res_o   (alu_res),
        .wb_data_o   (wb_data),
        .target_o    (target),
        .redirect_o  (redirect)
    );

    rv_pc_unit u_pc_unit (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .redirect_i (redirect),
        .target_i   (target),
        .halt_req_i (ctrl.halt),
        .pc_o       (pc),
        .commit_o   (commit),
        .halt_o     (halt_o)
    );

    assign imem_addr_o  = pc;
    assign dbus_o.addr  = alu_res;
    assign dbus_o.wdata = rs2_data;
    assign dbus_o.wen   = ctrl.mem_wen & commit; // one-cycle strobe

endmodule

//--- src/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

    localparam logic [31:0] INST_ECALL = 32'h0000_0073;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_JALR
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_op_e;

    typedef enum logic {OP1_RS1, OP1_PC} op1_sel_e;
    typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        br_op_e   br_op;
        op1_sel_e op1_sel;
        op2_sel_e op2_sel;
        wb_sel_e  wb_sel;
        logic     mem_wen;
        logic     rf_wen;
        logic     jump;
        logic     halt;
    } ctrl_t;

    // no writes, no branch
    localparam ctrl_t CTRL_NOP = '{
        alu_op:  ALU_ADD,
        br_op:   BR_NONE,
        op1_sel: OP1_RS1,
        op2_sel: OP2_RS2,
        wb_sel:  WB_ALU,
        mem_wen: 1'b0,
        rf_wen:  1'b0,
        jump:    1'b0,
        halt:    1'b0
    };

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            wen;
    } dbus_t;

endpackage

//--- src/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic [31:0]                         inst_i,
    output rv_core_pkg::ctrl_t                  ctrl_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]  rs2_addr_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]  rd_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]        imm_o
);
    import rv_core_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            is_op;   // register form, else immediate form
    logic            f7_ok;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign is_op  = (opcode == OPC_OP);

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OPC_LOAD, OPC_OP_IMM, OPC_JALR: imm_o = imm_i;
            OPC_STORE:  imm_o = imm_s;
            OPC_BRANCH: imm_o = imm_b;
            OPC_JAL:    imm_o = imm_j;
            default:    imm_o = '0;
        endcase
    end

    always_comb begin
        ctrl_o = CTRL_NOP;
        f7_ok  = 1'b0;
        case (opcode)
            OPC_LOAD: begin
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.wb_sel  = WB_MEM;
                ctrl_o.rf_wen  = (funct3 == F3_LW);
            end
            OPC_STORE: begin
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.mem_wen = (funct3 == F3_SW);
            end
            OPC_OP, OPC_OP_IMM: begin
                ctrl_o.op2_sel = is_op ? OP2_RS2 : OP2_IMM;
                case (funct3)
                    F3_ADD_SUB: begin
                        ctrl_o.alu_op = (is_op && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                        f7_ok = !is_op || funct7 == F7_BASE || funct7 == F7_ALT;
                    end
                    F3_SLL: begin
                        ctrl_o.alu_op = ALU_SLL;
                        f7_ok = (funct7 == F7_BASE);
                    end
                    F3_SRL_SRA: begin
                        ctrl_o.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        f7_ok = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                    F3_SLT:  ctrl_o.alu_op = ALU_SLT;
                    F3_SLTU: ctrl_o.alu_op = ALU_SLTU;
                    F3_XOR:  ctrl_o.alu_op = ALU_XOR;
                    F3_OR:   ctrl_o.alu_op = ALU_OR;
                    F3_AND:  ctrl_o.alu_op = ALU_AND;
                endcase
                // plain logic ops only need funct7 checked in register form
                if (funct3 inside {F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_AND})
                    f7_ok = !is_op || funct7 == F7_BASE;
                ctrl_o.rf_wen = f7_ok;
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  ctrl_o.br_op = BR_BEQ;
                    F3_BNE:  ctrl_o.br_op = BR_BNE;
                    F3_BLT:  ctrl_o.br_op = BR_BLT;
                    F3_BGE:  ctrl_o.br_op = BR_BGE;
                    F3_BLTU: ctrl_o.br_op = BR_BLTU;
                    F3_BGEU: ctrl_o.br_op = BR_BGEU;
                    default: ctrl_o.br_op = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                ctrl_o.op1_sel = OP1_PC;
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.wb_sel  = WB_PC4;
                ctrl_o.rf_wen  = 1'b1;
                ctrl_o.jump    = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == F3_JALR) begin
                    ctrl_o.alu_op  = ALU_JALR;
                    ctrl_o.op2_sel = OP2_IMM;
                    ctrl_o.wb_sel  = WB_PC4;
                    ctrl_o.rf_wen  = 1'b1;
                    ctrl_o.jump    = 1'b1;
                end
            end
            default: ctrl_o.halt = (inst_i == INST_ECALL);
        endcase
    end

endmodule

//--- src/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  rv_core_pkg::ctrl_t                  ctrl_i,
    input  logic [rv_core_pkg::XLEN-1:0]        pc_i,
    input  logic [rv_core_pkg::XLEN-1:0]        rs1_data_i,
    input  logic [rv_core_pkg::XLEN-1:0]        rs2_data_i,
    input  logic [rv_core_pkg::XLEN-1:0]        imm_i,
    input  logic [rv_core_pkg::XLEN-1:0]        mem_rdata_i,
    output logic [rv_core_pkg::XLEN-1:0]        alu_res_o,
    output logic [rv_core_pkg::XLEN-1:0]        wb_data_o,
    output logic [rv_core_pkg::XLEN-1:0]        target_o,
    output logic                                redirect_o
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] pc_plus4;
    logic [4:0]      shamt;
    logic            br_taken;

    assign op1   = (ctrl_i.op1_sel == OP1_PC) ? pc_i : rs1_data_i;
    assign op2   = (ctrl_i.op2_sel == OP2_IMM) ? imm_i : rs2_data_i;
    assign shamt = op2[4:0];
    assign sum   = op1 + op2;

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD:  alu_res_o = sum;
            ALU_SUB:  alu_res_o = op1 - op2;
            ALU_AND:  alu_res_o = op1 & op2;
            ALU_OR:   alu_res_o = op1 | op2;
            ALU_XOR:  alu_res_o = op1 ^ op2;
            ALU_SLL:  alu_res_o = op1 << shamt;
            ALU_SRL:  alu_res_o = op1 >> shamt;
            ALU_SRA:  alu_res_o = $unsigned($signed(op1) >>> shamt);
            ALU_SLT:  alu_res_o = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_SLTU: alu_res_o = {{(XLEN-1){1'b0}}, op1 < op2};
            ALU_JALR: alu_res_o = {sum[XLEN-1:1], 1'b0};
            default:  alu_res_o = '0;
        endcase
    end

    // compare always on the register pair
    always_comb begin
        case (ctrl_i.br_op)
            BR_BEQ:  br_taken = (rs1_data_i == rs2_data_i);
            BR_BNE:  br_taken = (rs1_data_i != rs2_data_i);
            BR_BLT:  br_taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
            BR_BGE:  br_taken = !($signed(rs1_data_i) < $signed(rs2_data_i));
            BR_BLTU: br_taken = (rs1_data_i < rs2_data_i);
            BR_BGEU: br_taken = !(rs1_data_i < rs2_data_i);
            default: br_taken = 1'b0;
        endcase
    end

    assign redirect_o = br_taken | ctrl_i.jump;
    assign target_o   = ctrl_i.jump ? alu_res_o : pc_i + imm_i; // jal adds pc in the alu
    assign pc_plus4   = pc_i + 32'd4;

    always_comb begin
        case (ctrl_i.wb_sel)
            WB_MEM:  wb_data_o = mem_rdata_i;
            WB_PC4:  wb_data_o = pc_plus4; // link value
            default: wb_data_o = alu_res_o;
        endcase
    end

endmodule

//--- src/rv_pc_unit.sv
`timescale 1ns/1ps

module rv_pc_unit (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            redirect_i,
    input  logic [rv_core_pkg::XLEN-1:0]    target_i,
    input  logic                            halt_req_i,
    output logic [rv_core_pkg::XLEN-1:0]    pc_o,
    output logic                            commit_o,
    output logic                            halt_o
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic            halted_q;

    // ecall keeps pc on itself
    always_comb begin
        if (halt_req_i)
            pc_next = pc_q;
        else if (redirect_i)
            pc_next = target_i;
        else
            pc_next = pc_q + 32'd4;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q     <= '0;
            halted_q <= 1'b0;
        end else if (commit_o) begin
            pc_q <= pc_next;
            if (halt_req_i)
                halted_q <= 1'b1;
        end
    end

    assign commit_o = rst_n_i & ~halted_q; // write enable for rf and dmem
    assign pc_o     = pc_q;
    assign halt_o   = halted_q;

endmodule

//--- src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                we_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0]  waddr_i,
    input  logic [rv_core_pkg::XLEN-1:0]        wdata_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0]  raddr1_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0]  raddr2_i,
    output logic [rv_core_pkg::XLEN-1:0]        rdata1_o,
    output logic [rv_core_pkg::XLEN-1:0]        rdata2_o
);
    import rv_core_pkg::*;

    localparam int NREGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs [1:NREGS-1]; // x0 has no storage

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam logic [6:0] I_ARITH = 7'b0010011;
localparam logic [6:0] I_LOAD  = 7'b0000011;
localparam logic [6:0] I_JALR  = 7'b1100111;

task automatic emit(input logic [31:0] word);
    rom[n_inst] = word;
    n_inst++;
endtask

task automatic op_r(input logic [2:0] f3, input logic [6:0] f7,
                    input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    emit({f7, rs2, rs1, f3, rd, 7'b0110011});
endtask

task automatic op_i(input logic [6:0] opc, input logic [2:0] f3,
                    input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    emit({imm, rs1, f3, rd, opc});
endtask

// sw rs2, off(x0)
task automatic store_word(input logic [4:0] rs2, input logic [11:0] off);
    emit({off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011});
endtask

task automatic store_expect(input logic [4:0] rs2, input logic [11:0] off,
                            input logic [31:0] val);
    store_word(rs2, off);
    exp_q.push_back({20'd0, off, val, 1'b1});
endtask

// branch forward by 8, over the next instruction
task automatic branch_skip(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    emit({1'b0, 6'd0, rs2, rs1, f3, 4'b0100, 1'b0, 7'b1100011});
endtask

// taken case hops a store that must never show, other case stores a marker
task automatic branch_pair(input logic [2:0] f3, input logic [4:0] t1, t2, n1, n2,
                           input logic [11:0] skip_off, mark_off);
    branch_skip(f3, t1, t2);
    store_word(5'd2, skip_off);
    branch_skip(f3, n1, n2);
    store_expect(5'd2, mark_off, 32'h0000_000C);
endtask

task automatic load_program();
    n_inst = 0;
    op_i(I_ARITH, 3'b000, 5'd1, 5'd0, -12'sd5);     // x1 = -5
    op_i(I_ARITH, 3'b000, 5'd2, 5'd0, 12'd12);      // x2 = 12
    op_r(3'b000, 7'h00, 5'd3, 5'd1, 5'd2);
    store_expect(5'd3, 12'h100, 32'h0000_0007);
    op_r(3'b000, 7'h20, 5'd3, 5'd1, 5'd2);          // sub
    store_expect(5'd3, 12'h104, 32'hFFFF_FFEF);
    op_r(3'b111, 7'h00, 5'd3, 5'd1, 5'd2);
    store_expect(5'd3, 12'h108, 32'h0000_0008);
    op_r(3'b110, 7'h00, 5'd3, 5'd1, 5'd2);
    store_expect(5'd3, 12'h10C, 32'hFFFF_FFFF);
    op_r(3'b100, 7'h00, 5'd3, 5'd1, 5'd2);
    store_expect(5'd3, 12'h110, 32'hFFFF_FFF7);
    op_i(I_ARITH, 3'b000, 5'd3, 5'd1, 12'd100);
    store_expect(5'd3, 12'h114, 32'h0000_005F);
    op_i(I_ARITH, 3'b111, 5'd3, 5'd1, 12'h0F0);
    store_expect(5'd3, 12'h118, 32'h0000_00F0);
    op_i(I_ARITH, 3'b110, 5'd3, 5'd2, 12'hF00);     // ori with -256
    store_expect(5'd3, 12'h11C, 32'hFFFF_FF0C);
    op_i(I_ARITH, 3'b100, 5'd3, 5'd1, 12'hFFF);
    store_expect(5'd3, 12'h120, 32'h0000_0004);
    op_i(I_ARITH, 3'b000, 5'd4, 5'd0, 12'd4);       // shift amount
    op_r(3'b001, 7'h00, 5'd3, 5'd1, 5'd4);
    store_expect(5'd3, 12'h124, 32'hFFFF_FFB0);
    op_r(3'b101, 7'h00, 5'd3, 5'd1, 5'd4);
    store_expect(5'd3, 12'h128, 32'h0FFF_FFFF);
    op_r(3'b101, 7'h20, 5'd3, 5'd1, 5'd4);
    store_expect(5'd3, 12'h12C, 32'hFFFF_FFFF);
    op_i(I_ARITH, 3'b001, 5'd3, 5'd1, 12'h008);
    store_expect(5'd3, 12'h130, 32'hFFFF_FB00);
    op_i(I_ARITH, 3'b101, 5'd3, 5'd1, 12'h01C);
    store_expect(5'd3, 12'h134, 32'h0000_000F);
    op_i(I_ARITH, 3'b101, 5'd3, 5'd1, 12'h401);     // srai 1
    store_expect(5'd3, 12'h138, 32'hFFFF_FFFD);
    op_r(3'b010, 7'h00, 5'd3, 5'd1, 5'd2);
    store_expect(5'd3, 12'h13C, 32'h0000_0001);
    op_r(3'b011, 7'h00, 5'd3, 5'd1, 5'd2);
    store_expect(5'd3, 12'h140, 32'h0000_0000);
    op_i(I_ARITH, 3'b010, 5'd3, 5'd2, 12'hFFF);
    store_expect(5'd3, 12'h144, 32'h0000_0000);
    op_i(I_ARITH, 3'b011, 5'd3, 5'd2, 12'hFFF);
    store_expect(5'd3, 12'h148, 32'h0000_0001);
    op_i(I_LOAD, 3'b010, 5'd5, 5'd0, 12'h040);
    op_r(3'b000, 7'h00, 5'd6, 5'd5, 5'd2);          // uses the loaded word
    store_expect(5'd6, 12'h14C, fill_word(16) + 32'd12);
    op_i(I_ARITH, 3'b000, 5'd0, 5'd0, 12'd55);
    store_expect(5'd0, 12'h150, 32'h0000_0000);
    branch_pair(3'b000, 5'd1, 5'd1, 5'd1, 5'd2, 12'h200, 12'h154);
    branch_pair(3'b001, 5'd1, 5'd2, 5'd2, 5'd2, 12'h204, 12'h158);
    branch_pair(3'b100, 5'd1, 5'd2, 5'd2, 5'd1, 12'h208, 12'h15C);
    branch_pair(3'b101, 5'd2, 5'd1, 5'd1, 5'd2, 12'h20C, 12'h160);
    branch_pair(3'b110, 5'd2, 5'd1, 5'd1, 5'd2, 12'h210, 12'h164);
    branch_pair(3'b111, 5'd1, 5'd2, 5'd2, 5'd1, 12'h214, 12'h168);
    emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd7, 7'b1101111}); // jal x7, +8 at 0x118
    store_word(5'd2, 12'h218);
    store_expect(5'd7, 12'h16C, 32'h0000_011C);
    op_i(I_JALR, 3'b000, 5'd8, 5'd7, 12'd21);       // odd target, lands on 0x130
    store_word(5'd2, 12'h21C);
    store_word(5'd2, 12'h220);
    store_expect(5'd8, 12'h170, 32'h0000_0128);
    ecall_pc = n_inst * 4;
    emit(32'h0000_0073);
    store_word(5'd2, 12'h224);
endtask

`endif

//--- verification/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int  ROM_AW    = 7;
    localparam int  RAM_AW    = 8;
    localparam int  ROM_WORDS = 2 ** ROM_AW;
    localparam int  RAM_WORDS = 2 ** RAM_AW;
    localparam time T_DRIVE   = 1ns;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_inst;
    dbus_t       dbus;
    logic [31:0] dmem_rdata;
    logic        halt;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] ram [RAM_WORDS];
    dbus_t       exp_q [$];
    int          n_inst;
    logic [31:0] ecall_pc;
    int          exp_idx;
    int          n_checks;
    int          n_errors;
    int          cycles;
    int          limit;

    function automatic logic [31:0] fill_word(int unsigned idx);
        return {idx[15:0] ^ 16'hC0DE, idx[15:0]};
    endfunction

    `include "tb_program.svh"

    rv_core u_rv_core (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_inst_i  (imem_inst),
        .dbus_o       (dbus),
        .dmem_rdata_i (dmem_rdata),
        .halt_o       (halt)
    );

    // combinational memories, no wait states
    assign imem_inst  = rom[imem_addr[ROM_AW+1:2]];
    assign dmem_rdata = ram[dbus.addr[RAM_AW+1:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (dbus.wen === 1'b1)
            ram[dbus.addr[RAM_AW+1:2]] <= dbus.wdata;
    end

    task automatic check_store(input dbus_t got, input dbus_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("CHECK FAILED dbus_o: addr %h wdata %h, expected addr %h wdata %h",
                     got.addr, got.wdata, exp.addr, exp.wdata);
            n_errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            n_errors++;
        end
    endtask

    // every store strobe against the next table entry
    always @(negedge clk) begin
        if (rst_n && dbus.wen === 1'b1) begin
            if (exp_idx < exp_q.size()) begin
                check_store(dbus, exp_q[exp_idx]);
            end else begin
                $display("unexpected store to address %h after the last expected one",
                         dbus.addr);
                n_errors++;
            end
            exp_idx++;
        end
    end

    initial begin
        rst_n    = 1'b0;
        exp_idx  = 0;
        n_checks = 0;
        n_errors = 0;
        cycles   = 0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = 32'h0000_0073; // a runaway pc halts somewhere wrong
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = fill_word(i);
        end
        load_program();
        limit = n_inst * 4 + 20;
        repeat (4) @(posedge clk);
        #T_DRIVE rst_n = 1'b1;
        while (halt !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (halt !== 1'b1) begin
            $display("timeout: the core did not halt within %0d cycles", limit);
            n_errors++;
        end
        repeat (3) @(negedge clk); // halted core stays quiet
        check_word("imem_addr_o", imem_addr, ecall_pc);
        check_word("halt_o", {31'd0, halt}, 32'd1);
        if (exp_idx < exp_q.size()) begin
            $display("only %0d of %0d expected stores were seen", exp_idx, exp_q.size());
            n_errors++;
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
